//--- sim.f
+incdir+bench
hw/monopixPkg.sv
hw/confRegister.sv
hw/bcidCounter.sv
hw/columnStore.sv
hw/wordSerializer.sv
hw/flavorReadout.sv
hw/monopixTop.sv
bench/monopixTb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module monopixTb -Mdir obj_dir -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Build or simulation did not complete, see build.log and sim.log"
grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- bench/readoutModel.svh
`ifndef READOUT_MODEL_SVH
`define READOUT_MODEL_SVH

// Reference state, advanced once per rising clock edge
logic [7:0]  mChain;
logic [3:0]  mEnFlavor;
logic [3:0]  mEnTp;
logic [5:0]  mBcid;  // Binary count
logic [3:0]  mOcc [monopixPkg::NumFlavors];
logic [7:0]  mRow [monopixPkg::NumFlavors][monopixPkg::NumCols];
logic [5:0]  mStamp [monopixPkg::NumFlavors][monopixPkg::NumCols];
logic        mBusy [monopixPkg::NumFlavors];
logic [15:0] mWord [monopixPkg::NumFlavors];
logic [3:0]  mPos [monopixPkg::NumFlavors];  // Bit on the line, 0 is the MSB
logic        mIsPattern [monopixPkg::NumFlavors];

function automatic logic [5:0] grayOf(input logic [5:0] b);
    grayOf = b ^ {1'b0, b[5:1]};
endfunction

function automatic logic [1:0] lowestCol(input logic [3:0] occ);
    lowestCol = 2'd0;
    for (int c = 3; c >= 0; c--) begin
        if (occ[c]) begin
            lowestCol = c[1:0];
        end
    end
endfunction

function automatic logic expToken(input int f);
    expToken = mEnFlavor[f] && (|mOcc[f]);
endfunction

function automatic logic expData(input int f);
    expData = mBusy[f] && mWord[f][4'd15 - mPos[f]];
endfunction

task automatic modelReset();
    mChain = '0;
    {mEnTp, mEnFlavor} = 8'h0F;  // All flavors on, no test pattern
    mBcid = '0;
    for (int f = 0; f < monopixPkg::NumFlavors; f++) begin
        mOcc[f] = '0;
        mBusy[f] = 1'b0;
        mPos[f] = '0;
        mWord[f] = '0;
        mIsPattern[f] = 1'b0;
    end
endtask

// Everything below uses the state from before the edge
task automatic modelStep();
    logic        tokenNow;
    logic        accept;
    logic        take;
    logic        hitOk;
    logic [1:0]  sel;
    logic [15:0] word;
    if (reset) begin
        modelReset();
    end else begin
        for (int f = 0; f < monopixPkg::NumFlavors; f++) begin
            tokenNow = mEnFlavor[f] && (|mOcc[f]);
            sel = lowestCol(mOcc[f]);
            accept = Read[f] && !mBusy[f] && (mEnTp[f] || tokenNow);
            take = accept && !mEnTp[f];
            word = mEnTp[f] ? 16'hA5C3 : {sel, mRow[f][sel], mStamp[f][sel]};
            hitOk = hitIn.valid && (hitIn.flavor == f[1:0]) && mEnFlavor[f] && !Freeze[f]
                && !mOcc[f][hitIn.column] && !(take && (sel == hitIn.column));
            if (take) begin
                mOcc[f][sel] = 1'b0;
            end
            if (hitOk) begin
                mOcc[f][hitIn.column] = 1'b1;
                mRow[f][hitIn.column] = hitIn.row;
                mStamp[f][hitIn.column] = grayOf(mBcid);
            end
            if (accept) begin
                mBusy[f] = 1'b1;
                mWord[f] = word;
                mPos[f] = '0;
                mIsPattern[f] = mEnTp[f];
            end else if (mBusy[f]) begin
                if (mPos[f] == 4'd15) begin
                    mBusy[f] = 1'b0;
                end else begin
                    mPos[f] = mPos[f] + 4'd1;
                end
            end
        end
        if (confIn.defConf) begin
            {mEnTp, mEnFlavor} = 8'h0F;
        end else if (confIn.load) begin
            {mEnTp, mEnFlavor} = mChain;
        end
        if (confIn.shift) begin
            mChain = {mChain[6:0], confIn.dataIn};
        end
        mBcid = ResetBcid ? 6'd0 : mBcid + 6'd1;
    end
endtask

`endif

//--- bench/monopixTb.sv
`timescale 1ns/1ps

module monopixTb;

    localparam int RandCycles = 2000;
    localparam int BcidRuns = 6;
    // Stamp runs wait up to 127 cycles each, plus config, drain and margin
    localparam int TimeoutCycles = BcidRuns * 160 + 3 * RandCycles + 1200;

    logic                              ClkBx;
    logic                              reset;
    logic                              ResetBcid;
    monopixPkg::confSerial             confIn;
    logic                              ConfOut;
    monopixPkg::hitEvent               hitIn;
    logic [monopixPkg::NumFlavors-1:0] Read;
    logic [monopixPkg::NumFlavors-1:0] Freeze;
    logic [monopixPkg::NumFlavors-1:0] Token;
    logic [monopixPkg::NumFlavors-1:0] DataOut;

    integer      seed;
    logic [31:0] rnd;
    int          errors;
    int          checks;
    int          hitWords;
    int          patternWords;
    logic        checkEn;
    logic [15:0] capWord [monopixPkg::NumFlavors];

    `include "readoutModel.svh"

    monopixTop DUT (
        .ClkBx(ClkBx),
        .reset(reset),
        .ResetBcid(ResetBcid),
        .confIn(confIn),
        .ConfOut(ConfOut),
        .hitIn(hitIn),
        .Read(Read),
        .Freeze(Freeze),
        .Token(Token),
        .DataOut(DataOut)
    );

    initial begin
        ClkBx = 1'b0;
        forever #50 ClkBx = ~ClkBx;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge ClkBx);
        $display("Timeout after %0d cycles, the test sequence never finished", TimeoutCycles);
        $display("*** FAILED ***");
        $finish;
    end

    always @(posedge ClkBx) modelStep();

    // Outputs are compared mid-cycle against the model
    always @(negedge ClkBx) begin
        if (checkEn) begin
            checks++;
            if (ConfOut !== mChain[7]) begin
                errors++;
                $display("MISMATCH ConfOut: got %h, expected %h", ConfOut, mChain[7]);
            end
            for (int f = 0; f < monopixPkg::NumFlavors; f++) begin
                if (Token[f] !== expToken(f)) begin
                    errors++;
                    $display("MISMATCH Token[%0d]: got %h, expected %h", f, Token[f], expToken(f));
                end
                if (DataOut[f] !== expData(f)) begin
                    errors++;
                    $display("MISMATCH DataOut[%0d]: got %h, expected %h",
                        f, DataOut[f], expData(f));
                end
                if (mBusy[f]) begin
                    capWord[f] = {capWord[f][14:0], DataOut[f]};
                    if (mPos[f] == 4'd15) begin
                        if (capWord[f] !== mWord[f]) begin
                            errors++;
                            $display("MISMATCH serial word of flavor %0d: got %h, expected %h",
                                f, capWord[f], mWord[f]);
                        end
                        if (mIsPattern[f]) patternWords++;
                        else hitWords++;
                    end
                end
            end
        end
    end

    task automatic tick();
        @(posedge ClkBx);
        #1;
    endtask

    task automatic shiftConf(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            confIn = '{shift: 1'b1, load: 1'b0, defConf: 1'b0, dataIn: value[i]};
            tick();
        end
        confIn = '0;
    endtask

    task automatic loadConf();
        confIn = '{shift: 1'b0, load: 1'b1, defConf: 1'b0, dataIn: 1'b0};
        tick();
        confIn = '0;
    endtask

    task automatic restoreDefaults();
        confIn = '{shift: 1'b0, load: 1'b0, defConf: 1'b1, dataIn: 1'b0};
        tick();
        confIn = '0;
    endtask

    // Chain comes back out MSB first
    task automatic readBackConf(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            if (ConfOut !== value[i]) begin
                errors++;
                $display("MISMATCH ConfOut bit %0d: got %h, expected %h", i, ConfOut, value[i]);
            end
            confIn = '{shift: 1'b1, load: 1'b0, defConf: 1'b0, dataIn: 1'b0};
            tick();
        end
        confIn = '0;
    endtask

    task automatic waitToken(input int f);
        int n;
        n = 0;
        while (!Token[f] && n < 8) begin
            tick();
            n++;
        end
        if (!Token[f]) begin
            errors++;
            $display("Token of flavor %0d did not rise within 8 cycles of a hit", f);
        end
    endtask

    task automatic stampRuns();
        int          k;
        int          pos;
        logic [5:0]  kk;
        logic [5:0]  expGray;
        logic [1:0]  col;
        logic [7:0]  row;
        logic [15:0] got;
        for (int n = 0; n < BcidRuns; n++) begin
            rnd = $random(seed);
            k = int'(rnd[6:0]);
            kk = rnd[5:0];  // k mod 64
            // Each Gray step flips the bit at the lowest set bit of the step number
            expGray = '0;
            for (int s = 1; s <= int'(kk); s++) begin
                pos = 0;
                while (s[pos] == 1'b0) begin
                    pos++;
                end
                expGray[pos] = ~expGray[pos];
            end
            col = rnd[9:8];
            row = rnd[23:16];
            ResetBcid = 1'b1;
            tick();
            ResetBcid = 1'b0;
            repeat (k) tick();
            hitIn = '{valid: 1'b1, flavor: 2'd0, column: col, row: row};
            tick();
            hitIn = '0;
            waitToken(0);
            Read[0] = 1'b1;
            tick();
            Read[0] = 1'b0;
            got = '0;
            for (int b = 0; b < 16; b++) begin
                got = {got[14:0], DataOut[0]};
                tick();
            end
            if (got[5:0] !== expGray) begin
                errors++;
                $display("MISMATCH bcid after %0d cycles: got %h, expected %h", k, got[5:0], expGray);
            end
            if (got[15:6] !== {col, row}) begin
                errors++;
                $display("MISMATCH column/row: got %h, expected %h", got[15:6], {col, row});
            end
        end
    endtask

    task automatic randomPhase(input int cycles);
        logic [31:0] r2;
        for (int n = 0; n < cycles; n++) begin
            rnd = $random(seed);
            r2 = $random(seed);
            hitIn = '{valid: rnd[12], flavor: rnd[14:13], column: rnd[16:15], row: rnd[24:17]};
            for (int f = 0; f < monopixPkg::NumFlavors; f++) begin
                Read[f] = (rnd[3*f +: 3] == 3'b000);
                if (r2[4*f +: 4] == 4'h0) begin
                    Freeze[f] = ~Freeze[f];  // Slow toggling
                end
            end
            ResetBcid = (r2[21:16] == 6'd0);
            tick();
        end
        hitIn = '0;
        Read = '0;
        Freeze = '0;
        ResetBcid = 1'b0;
    endtask

    initial begin
        logic [7:0] confValue;
        int         drainCycles;
        seed = 32'hdaf03c7d;
        errors = 0;
        checks = 0;
        hitWords = 0;
        patternWords = 0;
        checkEn = 1'b0;
        reset = 1'b1;
        ResetBcid = 1'b0;
        confIn = '0;
        hitIn = '0;
        Read = '0;
        Freeze = '0;
        repeat (5) tick();
        reset = 1'b0;
        checkEn = 1'b1;

        stampRuns();

        rnd = $random(seed);
        confValue = rnd[7:0];
        shiftConf(confValue);
        loadConf();
        readBackConf(confValue);
        randomPhase(RandCycles);

        restoreDefaults();
        randomPhase(RandCycles);

        // Test pattern on every flavor, stored hits must survive
        shiftConf(8'hFF);
        loadConf();
        randomPhase(RandCycles / 2);
        restoreDefaults();
        randomPhase(RandCycles / 2);

        // Hold Read on every flavor until all columns are empty
        Read = '1;
        drainCycles = 0;
        while (Token !== '0 && drainCycles < 100) begin
            tick();
            drainCycles++;
        end
        Read = '0;
        if (Token !== '0) begin
            errors++;
            $display("Token still set after %0d cycles of continuous Read", drainCycles);
        end
        repeat (monopixPkg::WordBits + 1) tick();  // Last word leaves the line

        if (hitWords == 0 || patternWords == 0) begin
            errors++;
            $display("The run never sent a hit word or never sent a test pattern word");
        end

        $display("Cycles checked: %0d, hit words: %0d, pattern words: %0d, errors: %0d",
            checks, hitWords, patternWords, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/monopixTop.sv
`timescale 1ns/1ps

module monopixTop (
    input  logic                              ClkBx,
    input  logic                              reset,
    input  logic                              ResetBcid,
    input  monopixPkg::confSerial             confIn,
    output logic                              ConfOut,
    input  monopixPkg::hitEvent               hitIn,
    input  logic [monopixPkg::NumFlavors-1:0] Read,
    input  logic [monopixPkg::NumFlavors-1:0] Freeze,
    output logic [monopixPkg::NumFlavors-1:0] Token,
    output logic [monopixPkg::NumFlavors-1:0] DataOut
);

    monopixPkg::monopixConf          conf;
    logic [monopixPkg::BcidBits-1:0] bcidGray;

    // Global configuration chain
    confRegister confReg (
        .ClkBx(ClkBx),
        .reset(reset),
        .confIn(confIn),
        .ConfOut(ConfOut),
        .conf(conf)
    );

    // Shared timestamp for all flavors
    bcidCounter bcid (
        .ClkBx(ClkBx),
        .reset(reset),
        .ResetBcid(ResetBcid),
        .bcidGray(bcidGray)
    );

    // One readout per pixel flavor
    for (genvar f = 0; f < monopixPkg::NumFlavors; f++) begin : genFlavor
        flavorReadout #(
            .FlavorIndex(f)
        ) readout (
            .ClkBx(ClkBx),
            .reset(reset),
            .hitIn(hitIn),
            .bcidGray(bcidGray),
            .enFlavor(conf.enFlavor[f]),
            .enTestPattern(conf.enTestPattern[f]),
            .Read(Read[f]),
            .Freeze(Freeze[f]),
            .Token(Token[f]),
            .DataOut(DataOut[f])
        );
    end

endmodule

//--- hw/flavorReadout.sv
`timescale 1ns/1ps

module flavorReadout #(
    parameter int FlavorIndex = 0
) (
    input  logic                            ClkBx,
    input  logic                            reset,
    input  monopixPkg::hitEvent             hitIn,
    input  logic [monopixPkg::BcidBits-1:0] bcidGray,
    input  logic                            enFlavor,
    input  logic                            enTestPattern,
    input  logic                            Read,
    input  logic                            Freeze,
    output logic                            Token,
    output logic                            DataOut
);

    logic                            serBusy;
    logic                            readAccept;
    logic                            take;
    logic [monopixPkg::WordBits-1:0] loadWord;
    monopixPkg::hitWord              selWord;

    // Read while busy or with nothing to send is dropped
    assign readAccept = Read && !serBusy && (enTestPattern || Token);

    // Test pattern leaves the stored hits alone
    assign take = readAccept && !enTestPattern;

    assign loadWord = enTestPattern ? monopixPkg::TestPattern : selWord;

    columnStore #(
        .FlavorIndex(FlavorIndex)
    ) store (
        .ClkBx(ClkBx),
        .reset(reset),
        .hitIn(hitIn),
        .bcidGray(bcidGray),
        .enable(enFlavor),
        .Freeze(Freeze),
        .take(take),
        .Token(Token),
        .selWord(selWord)
    );

    wordSerializer ser (
        .ClkBx(ClkBx),
        .reset(reset),
        .load(readAccept),
        .word(loadWord),
        .busy(serBusy),
        .DataOut(DataOut)
    );

endmodule

//--- hw/wordSerializer.sv
`timescale 1ns/1ps

module wordSerializer (
    input  logic                            ClkBx,
    input  logic                            reset,
    input  logic                            load,
    input  logic [monopixPkg::WordBits-1:0] word,
    output logic                            busy,
    output logic                            DataOut
);

    localparam int CntBits = $clog2(monopixPkg::WordBits);

    logic [monopixPkg::WordBits-1:0] shiftWord;
    logic [CntBits-1:0]              bitCnt;  // Bits left after the current one

    // Control state
    always_ff @(posedge ClkBx) begin
        if (reset) begin
            busy <= 1'b0;
            bitCnt <= '0;
        end else if (load && !busy) begin
            busy <= 1'b1;
            bitCnt <= CntBits'(monopixPkg::WordBits - 1);
        end else if (busy) begin
            if (bitCnt == '0) begin
                busy <= 1'b0;  // Last bit was on the line this cycle
            end else begin
                bitCnt <= bitCnt - 1'b1;
            end
        end
    end

    // Data path
    always_ff @(posedge ClkBx) begin
        if (load && !busy) begin
            shiftWord <= word;
        end else if (busy) begin
            shiftWord <= {shiftWord[monopixPkg::WordBits-2:0], 1'b0};
        end
    end

    // MSB first, quiet line when idle
    assign DataOut = busy && shiftWord[monopixPkg::WordBits-1];

endmodule

//--- hw/columnStore.sv
`timescale 1ns/1ps

module columnStore #(
    parameter int FlavorIndex = 0
) (
    input  logic                            ClkBx,
    input  logic                            reset,
    input  monopixPkg::hitEvent             hitIn,
    input  logic [monopixPkg::BcidBits-1:0] bcidGray,
    input  logic                            enable,
    input  logic                            Freeze,
    input  logic                            take,
    output logic                            Token,
    output monopixPkg::hitWord              selWord
);

    localparam int FlavorBits = $clog2(monopixPkg::NumFlavors);

    logic [monopixPkg::NumCols-1:0] occupied;
    logic [monopixPkg::NumCols-1:0] setMask;
    logic [monopixPkg::NumCols-1:0] clearMask;
    logic [monopixPkg::ColBits-1:0] selCol;
    logic                           forUs;
    logic                           colBusy;
    logic                           hitAccept;

    // Hit registers, payload only
    monopixPkg::hitWord hitReg [monopixPkg::NumCols];

    // Priority encoder, lowest occupied column wins
    always_comb begin
        selCol = '0;
        for (int i = monopixPkg::NumCols - 1; i >= 0; i--) begin
            if (occupied[i]) begin
                selCol = i[monopixPkg::ColBits-1:0];
            end
        end
    end

    assign selWord = hitReg[selCol];

    assign forUs = hitIn.valid && (hitIn.flavor == FlavorBits'(FlavorIndex));

    // Target column full or emptied this very cycle
    assign colBusy = occupied[hitIn.column] || (take && (selCol == hitIn.column));

    assign hitAccept = forUs && enable && !Freeze && !colBusy;

    always_comb begin
        setMask = '0;
        clearMask = '0;
        if (hitAccept) begin
            setMask[hitIn.column] = 1'b1;
        end
        if (take) begin
            clearMask[selCol] = 1'b1;
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            occupied <= (occupied & ~clearMask) | setMask;
        end
    end

    // Stamp with the BCID of the hit cycle
    always_ff @(posedge ClkBx) begin
        if (hitAccept) begin
            hitReg[hitIn.column] <= '{
                column: hitIn.column,
                row: hitIn.row,
                bcid: bcidGray
            };
        end
    end

    // Hits survive a disable, token just hidden
    assign Token = enable && (|occupied);

endmodule

//--- hw/bcidCounter.sv
`timescale 1ns/1ps

module bcidCounter (
    input  logic                          ClkBx,
    input  logic                          reset,
    input  logic                          ResetBcid,
    output logic [monopixPkg::BcidBits-1:0] bcidGray
);

    logic [monopixPkg::BcidBits-1:0] bcidBin;

    // Free running, wraps naturally at 64
    always_ff @(posedge ClkBx) begin
        if (reset || ResetBcid) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    // Only one bit flips per crossing
    assign bcidGray = bcidBin ^ (bcidBin >> 1);

endmodule

//--- hw/confRegister.sv
`timescale 1ns/1ps

module confRegister (
    input  logic                   ClkBx,
    input  logic                   reset,
    input  monopixPkg::confSerial  confIn,
    output logic                   ConfOut,
    output monopixPkg::monopixConf conf
);

    logic [monopixPkg::ConfBits-1:0] shiftChain;

    // Serial chain, new bit enters at the LSB
    always_ff @(posedge ClkBx) begin
        if (reset) begin
            shiftChain <= '0;
        end else if (confIn.shift) begin
            shiftChain <= {shiftChain[monopixPkg::ConfBits-2:0], confIn.dataIn};
        end
    end

    // Readback from the far end of the chain
    assign ConfOut = shiftChain[monopixPkg::ConfBits-1];

    // Active copy
    // load samples the chain as it was before this edge
    always_ff @(posedge ClkBx) begin
        if (reset) begin
            conf <= monopixPkg::DefaultConf;
        end else if (confIn.defConf) begin
            conf <= monopixPkg::DefaultConf;  // Defaults win over load
        end else if (confIn.load) begin
            conf <= monopixPkg::monopixConf'(shiftChain);
        end
    end

endmodule

//--- hw/monopixPkg.sv
package monopixPkg;

    // Readout geometry
    localparam int NumFlavors = 4;  // PMOS, PMOS DPW, comparator, HV
    localparam int NumCols = 4;
    localparam int ColBits = 2;
    localparam int RowBits = 8;
    localparam int BcidBits = 6;
    localparam int WordBits = 16;
    localparam int ConfBits = 8;

    // Fixed word sent instead of hit data
    localparam logic [WordBits-1:0] TestPattern = 16'hA5C3;

    // Hit coming from the pixel matrix, valid is a one-cycle strobe
    typedef struct packed {
        logic valid;
        logic [$clog2(NumFlavors)-1:0] flavor;
        logic [ColBits-1:0] column;
        logic [RowBits-1:0] row;
    } hitEvent;

    // Serial output word, column in the MSBs
    typedef struct packed {
        logic [ColBits-1:0] column;
        logic [RowBits-1:0] row;
        logic [BcidBits-1:0] bcid;  // Gray coded
    } hitWord;

    // Global configuration, bit i of each field is flavor i
    typedef struct packed {
        logic [NumFlavors-1:0] enTestPattern;
        logic [NumFlavors-1:0] enFlavor;
    } monopixConf;

    // Serial configuration port
    typedef struct packed {
        logic shift;    // Shift strobe
        logic load;     // Copy chain into active conf
        logic defConf;  // Reload defaults
        logic dataIn;
    } confSerial;

    localparam monopixConf DefaultConf = '{
        enTestPattern: '0,
        enFlavor: '1
    };

endpackage
